// File: Bender.yml
package:
  name: exec_stage

sources:
  - exec_pkg.sv
  - wb_if.sv
  - alu.sv
  - bitmanip_unit.sv
  - mul_unit.sv
  - branch_resolve.sv
  - exec_ctrl.sv
  - exec_stage.sv
  - target: test
    files:
      - exec_stage_chk.sv
      - exec_scoreboard.sv
      - tb_exec_stage.sv

// File: alu.sv
// Integer ALU with add, subtract, logic, shift and set-less-than operations
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  exec_pkg::word_t value1_i,
    input  exec_pkg::word_t value2_i,
    input  exec_pkg::op_t   op_i,
    output exec_pkg::word_t result_o
);
    import exec_pkg::*;

    logic [4:0] shamt;      // Only low five bits shift

    assign shamt = value2_i[4:0];

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = value1_i + value2_i;
            end
            OP_SUB: begin
                result_o = value1_i - value2_i;
            end
            OP_AND: begin
                result_o = value1_i & value2_i;
            end
            OP_OR: begin
                result_o = value1_i | value2_i;
            end
            OP_XOR: begin
                result_o = value1_i ^ value2_i;
            end
            OP_SLL: begin
                result_o = value1_i << shamt;
            end
            OP_SRL: begin
                result_o = value1_i >> shamt;
            end
            OP_SRA: begin
                result_o = word_t'($signed(value1_i) >>> shamt);
            end
            OP_SLT: begin
                result_o = word_t'($signed(value1_i) < $signed(value2_i));
            end
            OP_SLTU: begin
                result_o = word_t'(value1_i < value2_i);
            end
            default: begin
                result_o = '0;  // Unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: bitmanip_unit.sv
// Bit-manipulation unit with byte reverse, ctz, popcount, pack, shift-add and Hamming distance
`timescale 1ns/1ns
`default_nettype none

module bitmanip_unit (
    input  exec_pkg::word_t value1_i,
    input  exec_pkg::word_t value2_i,
    input  exec_pkg::op_t   op_i,
    output exec_pkg::word_t result_o
);
    import exec_pkg::*;

    function automatic word_t popcount(input word_t v);
        word_t cnt;
        cnt = '0;
        for (int i = 0; i < 32; i++) begin
            cnt = cnt + word_t'(v[i]);
        end
        return cnt;
    endfunction

    function automatic word_t trailing_zeros(input word_t v);
        word_t cnt;
        cnt = 32'd32;                   // All zero input
        for (int i = 31; i >= 0; i--) begin
            if (v[i]) begin
                cnt = word_t'(i);       // Lowest set bit wins
            end
        end
        return cnt;
    endfunction

    always_comb begin
        case (op_i)
            OP_RVRS:  result_o = {value1_i[7:0], value1_i[15:8],
                                  value1_i[23:16], value1_i[31:24]};
            OP_CNTZ:  result_o = trailing_zeros(value1_i);
            OP_CNTP:  result_o = popcount(value1_i);
            OP_PKG:   result_o = {value2_i[15:0], value1_i[15:0]};
            OP_SLADD: result_o = (value1_i << 1) + value2_i;
            OP_HMDST: result_o = popcount(value1_i ^ value2_i);
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: branch_resolve.sv
// Branch condition evaluation and jump target from the ALU result
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
    input  exec_pkg::br_t   br_i,
    input  exec_pkg::cmp_t  cmp_i,
    input  exec_pkg::word_t alu_result_i,   // rs1+imm or pc+imm
    output exec_pkg::pc_t   target_o,
    output logic            taken_o
);
    import exec_pkg::*;

    always_comb begin
        case (br_i)
            BR_EQ:   taken_o =  cmp_i[CMP_EQ];
            BR_NE:   taken_o = ~cmp_i[CMP_EQ];
            BR_LT:   taken_o =  cmp_i[CMP_LT];
            BR_GE:   taken_o = ~cmp_i[CMP_LT];
            BR_LTU:  taken_o =  cmp_i[CMP_LTU];
            BR_GEU:  taken_o = ~cmp_i[CMP_LTU];
            BR_JAL:  taken_o = 1'b1;
            BR_JALR: taken_o = 1'b1;
            default: taken_o = 1'b0;    // Fetch reads this every cycle
        endcase
    end

    assign target_o = alu_result_i[31:1];

endmodule

`default_nettype wire

// File: compile.f
exec_pkg.sv
wb_if.sv
alu.sv
bitmanip_unit.sv
mul_unit.sv
branch_resolve.sv
exec_ctrl.sv
exec_stage.sv
exec_stage_chk.sv
exec_scoreboard.sv
tb_exec_stage.sv

// File: exec_ctrl.sv
// Result select, forwarding outputs and writeback register of the execute stage
`timescale 1ns/1ns
`default_nettype none

module exec_ctrl (
    input  logic               clk_i,
    input  logic               rst_i,
    input  exec_pkg::unit_t    unit_i,
    input  exec_pkg::br_t      br_i,
    input  exec_pkg::reg_addr_t rd_addr_i,
    input  exec_pkg::pc_t      pc_inc_i,
    input  exec_pkg::word_t    alu_result_i,
    input  exec_pkg::word_t    bm_result_i,
    output exec_pkg::word_t    fwd_value_o,
    output logic               fwd_valid_o,
    wb_if.driver               wb
);
    import exec_pkg::*;

    word_t   result;
    wb_src_t src_next;
    logic    is_jump;
    logic    is_cond_br;
    logic    wen_next;

    assign is_jump    = (br_i == BR_JAL) || (br_i == BR_JALR);
    assign is_cond_br = br_i inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};

    assign result      = (unit_i == UNIT_BM) ? bm_result_i : alu_result_i;
    assign fwd_value_o = result;
    assign fwd_valid_o = (unit_i != UNIT_MUL);     // Product arrives next cycle

    always_comb begin
        if (is_jump) begin
            src_next = WB_PC;
        end else if (unit_i == UNIT_MUL) begin
            src_next = WB_MUL;
        end else begin
            src_next = WB_RESULT;
        end
    end

    // No write to x0 and none for conditional branches
    assign wen_next = (rd_addr_i != '0) &&
                      (is_jump || ((unit_i != UNIT_NONE) && !is_cond_br));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb.wen      <= 1'b0;
            wb.src      <= WB_RESULT;
            wb.rd_addr  <= '0;
            wb.rd_value <= '0;
        end else begin
            wb.wen      <= wen_next;
            wb.src      <= src_next;
            wb.rd_addr  <= rd_addr_i;
            wb.rd_value <= result;
        end
    end

    always_ff @(posedge clk_i) begin
        wb.pc_inc <= pc_inc_i;  // Link value for WB_PC
    end

endmodule

`default_nettype wire

// File: exec_pkg.sv
// Execute stage width typedefs with unit, operation, branch and writeback codes
`default_nettype none

package exec_pkg;

    typedef logic [31:0] word_t;        // Operand or result word
    typedef logic [31:1] pc_t;          // PC without bit 0
    typedef logic [4:0]  reg_addr_t;    // Register file address
    typedef logic [1:0]  unit_t;        // Functional unit select
    typedef logic [3:0]  op_t;          // Per-unit operation code
    typedef logic [3:0]  br_t;          // Branch or jump code
    typedef logic [2:0]  cmp_t;         // {lt, ltu, eq}
    typedef logic [1:0]  wb_src_t;      // Writeback source select

    // Unit select
    localparam unit_t UNIT_NONE = 2'd0;
    localparam unit_t UNIT_ALU  = 2'd1;
    localparam unit_t UNIT_BM   = 2'd2;
    localparam unit_t UNIT_MUL  = 2'd3;

    // ALU codes
    localparam op_t OP_ADD  = 4'd0;
    localparam op_t OP_SUB  = 4'd1;
    localparam op_t OP_AND  = 4'd2;
    localparam op_t OP_OR   = 4'd3;
    localparam op_t OP_XOR  = 4'd4;
    localparam op_t OP_SLL  = 4'd5;
    localparam op_t OP_SRL  = 4'd6;
    localparam op_t OP_SRA  = 4'd7;
    localparam op_t OP_SLT  = 4'd8;
    localparam op_t OP_SLTU = 4'd9;

    // Bit-manipulation codes reuse the ALU code space
    localparam op_t OP_RVRS  = 4'd0;
    localparam op_t OP_CNTZ  = 4'd1;
    localparam op_t OP_CNTP  = 4'd2;
    localparam op_t OP_PKG   = 4'd3;
    localparam op_t OP_SLADD = 4'd4;
    localparam op_t OP_HMDST = 4'd5;

    // Multiplier codes
    localparam op_t OP_MUL    = 4'd0;
    localparam op_t OP_MULH   = 4'd1;
    localparam op_t OP_MULHSU = 4'd2;
    localparam op_t OP_MULHU  = 4'd3;

    // Branch codes
    localparam br_t BR_NONE = 4'd0;
    localparam br_t BR_EQ   = 4'd1;
    localparam br_t BR_NE   = 4'd2;
    localparam br_t BR_LT   = 4'd3;
    localparam br_t BR_GE   = 4'd4;
    localparam br_t BR_LTU  = 4'd5;
    localparam br_t BR_GEU  = 4'd6;
    localparam br_t BR_JAL  = 4'd7;
    localparam br_t BR_JALR = 4'd8;

    // Bit positions inside cmp_t
    localparam int CMP_LT  = 2;
    localparam int CMP_LTU = 1;
    localparam int CMP_EQ  = 0;

    // Writeback source
    localparam wb_src_t WB_RESULT = 2'd0;
    localparam wb_src_t WB_PC     = 2'd1;
    localparam wb_src_t WB_MUL    = 2'd2;

endpackage

`default_nettype wire

// File: exec_scoreboard.sv
// Reference model and output comparison for the execute stage
`timescale 1ns/1ns
`default_nettype none

module exec_scoreboard #(
    parameter int CLK_PERIOD = 40
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  exec_pkg::unit_t     unit_i,
    input  exec_pkg::op_t       op_i,
    input  exec_pkg::br_t       br_i,
    input  exec_pkg::reg_addr_t rd_addr_i,
    input  exec_pkg::pc_t       pc_inc_i,
    input  exec_pkg::word_t     value1_i,
    input  exec_pkg::word_t     value2_i,
    input  exec_pkg::cmp_t      cmp_i,
    input  exec_pkg::pc_t       jump_target_i,
    input  logic                jump_taken_i,
    input  exec_pkg::word_t     fwd_value_i,
    input  logic                fwd_valid_i,
    input  exec_pkg::reg_addr_t wb_rd_addr_i,
    input  exec_pkg::pc_t       wb_pc_inc_i,
    input  exec_pkg::word_t     wb_rd_value_i,
    input  exec_pkg::word_t     wb_mul_value_i,
    input  exec_pkg::wb_src_t   wb_src_i,
    input  logic                wb_wen_i,
    output int                  error_count_o,
    output int                  check_count_o
);
    import exec_pkg::*;

    // Expected registered outputs for the operation sampled at the next edge
    logic      prev_rst;
    logic      exp_wen;
    wb_src_t   exp_src;
    reg_addr_t exp_rd_addr;
    pc_t       exp_pc_inc;
    word_t     exp_rd_value;
    word_t     exp_mul;
    logic      exp_is_mul;

    function automatic word_t alu_model(input op_t op, input word_t a, input word_t b);
        int unsigned sh;
        sh = b % 32;                        // Shift amount wraps at 32
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return word_t'($signed(a) >>> sh);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic word_t bm_model(input op_t op, input word_t a, input word_t b);
        word_t r;
        int    n;
        r = '0;
        n = 0;
        case (op)
            OP_RVRS: begin
                for (int i = 0; i < 4; i++) begin
                    r[8*i +: 8] = a[8*(3-i) +: 8];
                end
            end
            OP_CNTZ: begin
                while (n < 32 && !a[n]) begin
                    n++;
                end
                r = word_t'(n);             // 32 when no bit is set
            end
            OP_CNTP:  r = word_t'($countones(a));
            OP_PKG:   r = {b[15:0], a[15:0]};
            OP_SLADD: r = a * 2 + b;
            OP_HMDST: r = word_t'($countones(a ^ b));
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t mul_model(input op_t op, input word_t a, input word_t b);
        logic [63:0] p;
        case (op)
            OP_MUL:    p = {32'b0, a} * {32'b0, b};
            OP_MULH:   p = longint'($signed(a)) * longint'($signed(b));
            OP_MULHSU: p = longint'($signed(a)) * longint'({32'b0, b});
            default:   p = {32'b0, a} * {32'b0, b};
        endcase
        return (op == OP_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic taken_model(input br_t br, input cmp_t c);
        case (br)
            BR_EQ:   return c[CMP_EQ];
            BR_NE:   return !c[CMP_EQ];
            BR_LT:   return c[CMP_LT];
            BR_GE:   return !c[CMP_LT];
            BR_LTU:  return c[CMP_LTU];
            BR_GEU:  return !c[CMP_LTU];
            BR_JAL:  return 1'b1;
            BR_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count_o++;
        if (act !== exp) begin
            error_count_o++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_cycle();
        word_t alu_exp;
        word_t fwd_exp;
        logic  jump;
        logic  cond_br;
        alu_exp = alu_model(op_i, value1_i, value2_i);
        fwd_exp = (unit_i == UNIT_BM) ? bm_model(op_i, value1_i, value2_i) : alu_exp;
        jump    = (br_i == BR_JAL) || (br_i == BR_JALR);
        cond_br = (br_i >= BR_EQ) && (br_i <= BR_GEU);

        compare("jump_taken_o", taken_model(br_i, cmp_i), jump_taken_i);
        compare("jump_target_o", alu_exp[31:1], jump_target_i);
        compare("fwd_value_o", fwd_exp, fwd_value_i);
        compare("fwd_valid_o", unit_i != UNIT_MUL, fwd_valid_i);

        if (prev_rst) begin             // Register still holds reset values
            compare("wb_wen_o", 1'b0, wb_wen_i);
            compare("wb_src_o", WB_RESULT, wb_src_i);
            compare("wb_rd_addr_o", '0, wb_rd_addr_i);
            compare("wb_rd_value_o", '0, wb_rd_value_i);
            compare("wb_mul_value_o", '0, wb_mul_value_i);
        end else begin
            compare("wb_wen_o", exp_wen, wb_wen_i);
            compare("wb_src_o", exp_src, wb_src_i);
            compare("wb_rd_addr_o", exp_rd_addr, wb_rd_addr_i);
            compare("wb_pc_inc_o", exp_pc_inc, wb_pc_inc_i);
            compare("wb_rd_value_o", exp_rd_value, wb_rd_value_i);
            if (exp_is_mul) begin
                compare("wb_mul_value_o", exp_mul, wb_mul_value_i);
            end
        end

        prev_rst     = rst_i;
        exp_wen      = (rd_addr_i != 0) && (jump || (unit_i != UNIT_NONE && !cond_br));
        exp_src      = jump ? WB_PC : ((unit_i == UNIT_MUL) ? WB_MUL : WB_RESULT);
        exp_rd_addr  = rd_addr_i;
        exp_pc_inc   = pc_inc_i;
        exp_rd_value = fwd_exp;
        exp_mul      = mul_model(op_i, value1_i, value2_i);
        exp_is_mul   = (unit_i == UNIT_MUL);
    endtask

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        prev_rst      = 1'b1;           // First edge is inside reset
        exp_is_mul    = 1'b0;
        forever begin
            @(posedge clk_i);
            #(CLK_PERIOD - 1);          // Just before the next rising edge
            check_cycle();
        end
    end

endmodule

`default_nettype wire

// File: exec_stage.sv
// Execute stage top level connecting ALU, bit-manip, multiplier, branch and control blocks
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  exec_pkg::unit_t     unit_i,
    input  exec_pkg::op_t       op_i,
    input  exec_pkg::br_t       br_i,
    input  exec_pkg::reg_addr_t rd_addr_i,
    input  exec_pkg::pc_t       pc_inc_i,
    input  exec_pkg::word_t     value1_i,
    input  exec_pkg::word_t     value2_i,
    input  exec_pkg::cmp_t      cmp_i,      // {lt, ltu, eq}
    output exec_pkg::pc_t       jump_target_o,
    output logic                jump_taken_o,
    output exec_pkg::word_t     fwd_value_o,
    output logic                fwd_valid_o,
    output exec_pkg::reg_addr_t wb_rd_addr_o,
    output exec_pkg::pc_t       wb_pc_inc_o,
    output exec_pkg::word_t     wb_rd_value_o,
    output exec_pkg::word_t     wb_mul_value_o,
    output exec_pkg::wb_src_t   wb_src_o,
    output logic                wb_wen_o
);
    import exec_pkg::*;

    word_t alu_result;
    word_t bm_result;

    wb_if wb0 ();

    alu alu0 (
        .value1_i (value1_i),
        .value2_i (value2_i),
        .op_i     (op_i),
        .result_o (alu_result)
    );

    bitmanip_unit bm0 (
        .value1_i (value1_i),
        .value2_i (value2_i),
        .op_i     (op_i),
        .result_o (bm_result)
    );

    mul_unit mul0 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .value1_i (value1_i),
        .value2_i (value2_i),
        .op_i     (op_i),
        .result_o (wb_mul_value_o)  // Already aligned with writeback
    );

    branch_resolve br0 (
        .br_i         (br_i),
        .cmp_i        (cmp_i),
        .alu_result_i (alu_result),
        .target_o     (jump_target_o),
        .taken_o      (jump_taken_o)
    );

    exec_ctrl ctrl0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .unit_i       (unit_i),
        .br_i         (br_i),
        .rd_addr_i    (rd_addr_i),
        .pc_inc_i     (pc_inc_i),
        .alu_result_i (alu_result),
        .bm_result_i  (bm_result),
        .fwd_value_o  (fwd_value_o),
        .fwd_valid_o  (fwd_valid_o),
        .wb           (wb0.driver)
    );

    // Writeback bundle out to plain ports
    assign wb_rd_addr_o  = wb0.rd_addr;
    assign wb_pc_inc_o   = wb0.pc_inc;
    assign wb_rd_value_o = wb0.rd_value;
    assign wb_src_o      = wb0.src;
    assign wb_wen_o      = wb0.wen;

endmodule

`default_nettype wire

// File: exec_stage_chk.sv
// Bound assertion checker for execute stage reset and output consistency rules
`timescale 1ns/1ns
`default_nettype none

module exec_stage_chk (
    input  logic                clk_i,
    input  logic                rst_i,
    input  exec_pkg::unit_t     unit_i,
    input  exec_pkg::br_t       br_i,
    input  logic                jump_taken_i,
    input  logic                fwd_valid_i,
    input  logic                wb_wen_i,
    input  exec_pkg::reg_addr_t wb_rd_addr_i
);
    import exec_pkg::*;

    int unsigned fail_count;    // Read by the testbench top

    initial fail_count = 0;

    wen_after_reset: assert property (@(posedge clk_i) rst_i |=> !wb_wen_i)
        else begin
            $error("wb_wen_o high in the cycle after reset");
            fail_count++;
        end

    no_taken_without_branch: assert property (@(posedge clk_i)
        (br_i == BR_NONE) |-> !jump_taken_i)
        else begin
            $error("jump_taken_o high without a branch");
            fail_count++;
        end

    no_fwd_on_mul: assert property (@(posedge clk_i) (unit_i == UNIT_MUL) |-> !fwd_valid_i)
        else begin
            $error("fwd_valid_o high during a multiply");
            fail_count++;
        end

    no_write_to_x0: assert property (@(posedge clk_i) wb_wen_i |-> (wb_rd_addr_i != '0))
        else begin
            $error("wb_wen_o high with register zero as destination");
            fail_count++;
        end

endmodule

bind exec_stage exec_stage_chk chk0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .unit_i       (unit_i),
    .br_i         (br_i),
    .jump_taken_i (jump_taken_o),
    .fwd_valid_i  (fwd_valid_o),
    .wb_wen_i     (wb_wen_o),
    .wb_rd_addr_i (wb_rd_addr_o)
);

`default_nettype wire

// File: mul_unit.sv
// Registered 32x32 multiplier for MUL, MULH, MULHSU and MULHU
`timescale 1ns/1ns
`default_nettype none

module mul_unit (
    input  logic            clk_i,
    input  logic            rst_i,
    input  exec_pkg::word_t value1_i,
    input  exec_pkg::word_t value2_i,
    input  exec_pkg::op_t   op_i,
    output exec_pkg::word_t result_o
);
    import exec_pkg::*;

    logic        sign1;
    logic        sign2;
    logic [32:0] operand1;      // One extra bit for sign or zero extension
    logic [32:0] operand2;
    logic [65:0] product;

    always_comb begin
        case (op_i)
            OP_MULH: begin
                sign1 = 1'b1;
                sign2 = 1'b1;
            end
            OP_MULHSU: begin
                sign1 = 1'b1;   // rs1 signed, rs2 unsigned
                sign2 = 1'b0;
            end
            default: begin
                sign1 = 1'b0;   // MUL low word is the same either way
                sign2 = 1'b0;
            end
        endcase
    end

    assign operand1 = {sign1 & value1_i[31], value1_i};
    assign operand2 = {sign2 & value2_i[31], value2_i};
    assign product  = 66'($signed(operand1) * $signed(operand2));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
        end else begin
            result_o <= (op_i == OP_MUL) ? product[31:0] : product[63:32];
        end
    end

endmodule

`default_nettype wire

// File: tb_exec_stage.sv
// Testbench top with clock, reset, LFSR stimulus, watchdog and final report
`timescale 1ns/1ns
`default_nettype none

module tb_exec_stage;
    import exec_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_OPS      = 2000;
    localparam int DRIVE_DELAY  = 2;

    logic      clk_i;
    logic      rst_i;
    unit_t     unit_i;
    op_t       op_i;
    br_t       br_i;
    reg_addr_t rd_addr_i;
    pc_t       pc_inc_i;
    word_t     value1_i;
    word_t     value2_i;
    cmp_t      cmp_i;
    pc_t       jump_target_o;
    logic      jump_taken_o;
    word_t     fwd_value_o;
    logic      fwd_valid_o;
    reg_addr_t wb_rd_addr_o;
    pc_t       wb_pc_inc_o;
    word_t     wb_rd_value_o;
    word_t     wb_mul_value_o;
    wb_src_t   wb_src_o;
    logic      wb_wen_o;

    logic [31:0] lfsr_state;
    int          sb_errors;
    int          sb_checks;
    int          total_errors;

    exec_stage dut0 (.*);

    exec_scoreboard #(.CLK_PERIOD(CLK_PERIOD)) sb0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .unit_i         (unit_i),
        .op_i           (op_i),
        .br_i           (br_i),
        .rd_addr_i      (rd_addr_i),
        .pc_inc_i       (pc_inc_i),
        .value1_i       (value1_i),
        .value2_i       (value2_i),
        .cmp_i          (cmp_i),
        .jump_target_i  (jump_target_o),
        .jump_taken_i   (jump_taken_o),
        .fwd_value_i    (fwd_value_o),
        .fwd_valid_i    (fwd_valid_o),
        .wb_rd_addr_i   (wb_rd_addr_o),
        .wb_pc_inc_i    (wb_pc_inc_o),
        .wb_rd_value_i  (wb_rd_value_o),
        .wb_mul_value_i (wb_mul_value_o),
        .wb_src_i       (wb_src_o),
        .wb_wen_i       (wb_wen_o),
        .error_count_o  (sb_errors),
        .check_count_o  (sb_checks)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic draw_operand(output word_t v);
        logic [31:0] r;
        draw_bits(3, r);
        if (r == 0) begin               // Corner values about one time in eight
            draw_bits(2, r);
            case (r % 3)
                0:       v = 32'h0000_0000;
                1:       v = 32'hffff_ffff;
                default: v = 32'h8000_0000;
            endcase
        end else begin
            draw_bits(32, r);
            v = r;
        end
    endtask

    task automatic set_operands(input word_t a, input word_t b);
        value1_i = a;
        value2_i = b;
        cmp_i    = {$signed(a) < $signed(b), a < b, a == b};    // Flags as decode forms them
    endtask

    task automatic drive_idle();
        unit_i    = UNIT_NONE;
        op_i      = OP_ADD;
        br_i      = BR_NONE;
        rd_addr_i = '0;
        pc_inc_i  = '0;
        set_operands('0, '0);
    endtask

    task automatic drive_random_op();
        logic [31:0] r;
        word_t       a;
        word_t       b;
        draw_bits(2, r);
        unit_i = unit_t'(r[1:0]);
        case (unit_i)
            UNIT_BM: begin
                draw_bits(3, r);
                op_i = op_t'(r % 6);
            end
            UNIT_MUL: begin
                draw_bits(2, r);
                op_i = op_t'(r);
            end
            default: begin
                draw_bits(4, r);
                op_i = op_t'(r % 10);
            end
        endcase
        draw_bits(4, r);
        br_i = br_t'(r % 9);
        draw_bits(5, r);
        rd_addr_i = reg_addr_t'(r);
        draw_bits(31, r);
        pc_inc_i = pc_t'(r);
        draw_operand(a);
        draw_operand(b);
        set_operands(a, b);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        lfsr_state = 32'ha1b2;
        rst_i      = 1'b1;
        // Live operations during reset so the cleared registers are visible
        for (int i = 0; i < RESET_CYCLES; i++) begin
            drive_random_op();
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
        rst_i = 1'b0;
        for (int i = 0; i < NUM_OPS; i++) begin
            drive_random_op();
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
        drive_idle();
        repeat (3) @(posedge clk_i);    // Let the last result drain
        #DRIVE_DELAY;
        total_errors = sb_errors + int'(dut0.chk0.fail_count);
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 sb_checks, sb_errors, dut0.chk0.fail_count);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + NUM_OPS + 20) * CLK_PERIOD);
        $display("ERROR: timeout, the run did not complete in the expected time");
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 sb_checks, sb_errors, dut0.chk0.fail_count);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_if.sv
// Writeback bundle interface with driver and receiver modports
`timescale 1ns/1ns
`default_nettype none

interface wb_if;
    import exec_pkg::*;

    reg_addr_t rd_addr;     // Destination register
    pc_t       pc_inc;      // Link value for jumps
    word_t     rd_value;    // Single-cycle unit result
    wb_src_t   src;         // Selects which value writeback uses
    logic      wen;         // Register file write enable

    modport driver (
        output rd_addr, pc_inc, rd_value, src, wen
    );

    modport receiver (
        input rd_addr, pc_inc, rd_value, src, wen
    );

endinterface

`default_nettype wire
